// ==== src.f ====
l2_cache_pkg.sv
l2_way_store.sv
l2_tag_lookup.sv
l2_ctrl_fsm.sv
l2_line_path.sv
l2_cache_top.sv
l2_cache_props.sv
tb_l2_cache.sv

// ==== Makefile ====
SRCS := $(wildcard *.sv)

obj_dir/Vtb_l2_cache: src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_l2_cache -f src.f

run: obj_dir/Vtb_l2_cache
	@out=$$(./obj_dir/Vtb_l2_cache); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== tb_l2_cache.sv ====
// testbench for the L2 cache
// applies a table of directed and LCG requests in a loop
// a delayed memory model and a per-word shadow model give the expected data
`timescale 1ns/1ps

module tb_l2_cache;

    typedef struct packed {
        l2_cache_pkg::l2_op_e op;
        logic [31:0]          addr;
        logic [127:0]         wdata;
        logic [2:0]           plru;
        logic                 use_shadow;
        logic [127:0]         exp;
        logic [1:0]           kind;
        logic [25:0]          wb_line;   // victim line of a dirty miss
    } vec_t;

    localparam logic [1:0] k_any   = 2'd0;
    localparam logic [1:0] k_hit   = 2'd1;
    localparam logic [1:0] k_clean = 2'd2;
    localparam logic [1:0] k_dirty = 2'd3;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 req;
    l2_cache_pkg::l2_op_e req_op;
    logic [31:0]          req_addr;
    logic [127:0]         req_wdata;
    logic [2:0]           plru;
    logic                 busy;
    logic                 rsp_valid;
    logic [127:0]         rsp_data;
    logic                 mem_req;
    logic                 mem_we;
    logic [25:0]          mem_addr;
    logic [511:0]         mem_wdata;
    logic [511:0]         mem_rdata = '0;
    logic                 mem_done = 1'b0;

    logic [31:0]  lcg_state = 32'h69c6168e;
    vec_t         tbl[$];
    logic [127:0] shadow [logic [27:0]];     // by word address
    logic [511:0] mem_lines [logic [25:0]];
    int           mem_wait = -1;
    int           rd_count = 0;
    int           wb_count = 0;
    logic [25:0]  last_rd_line;
    logic [25:0]  last_wb_line;
    logic [511:0] last_wb_data;
    int           cycles = 0;
    int           limit = 0;

    always #20 clk = ~clk;

    l2_cache_top uut (.*);

    bind l2_cache_top l2_cache_props u_props (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // each word carries its full line address and word number
    function automatic logic [127:0] pattern_word(input logic [25:0] line, input logic [1:0] w);
        return {6'h2a, line, 30'h0, w, ~{6'h15, line}, 30'h0abcdef, w};
    endfunction

    function automatic logic [511:0] pattern_line(input logic [25:0] line);
        logic [511:0] l;
        for (int w = 0; w < 4; w++) begin
            l[w*128 +: 128] = pattern_word(line, 2'(w));
        end
        return l;
    endfunction

    function automatic logic [127:0] shadow_word(input logic [27:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return pattern_word(a[27:2], a[1:0]);
    endfunction

    function automatic logic [511:0] shadow_line(input logic [25:0] line);
        logic [511:0] l;
        for (int w = 0; w < 4; w++) begin
            l[w*128 +: 128] = shadow_word({line, 2'(w)});
        end
        return l;
    endfunction

    function automatic logic [31:0] mk_addr(input int tag, input int set, input int w);
        return {17'(tag), 9'(set), 2'(w), 4'h0};
    endfunction

    function automatic void add_vec(input l2_cache_pkg::l2_op_e op, input logic [31:0] addr,
                                    input logic [127:0] wdata, input logic [2:0] pl,
                                    input logic [1:0] kind, input logic [25:0] wb_line);
        vec_t v;
        v.op         = op;
        v.addr       = addr;
        v.wdata      = wdata;
        v.plru       = pl;
        v.use_shadow = (op == l2_cache_pkg::op_read);
        v.exp        = (op == l2_cache_pkg::op_write) ? wdata : '0;  // write echoes its word
        v.kind       = kind;
        v.wb_line    = wb_line;
        tbl.push_back(v);
    endfunction

    function automatic void build_table();
        logic [31:0] r;
        int          ln;
        add_vec(l2_cache_pkg::op_read, mk_addr(1, 5, 2), '0, 3'd0, k_clean, '0);  // cold miss
        add_vec(l2_cache_pkg::op_read, mk_addr(1, 5, 0), '0, 3'd0, k_hit, '0);
        add_vec(l2_cache_pkg::op_write, mk_addr(1, 5, 1),
                128'h1111_2222_3333_4444_5555_6666_7777_8888, 3'd0, k_hit, '0);
        for (int w = 0; w < 4; w++) begin
            add_vec(l2_cache_pkg::op_read, mk_addr(1, 5, w), '0, 3'd0, k_hit, '0);
        end
        // write miss allocates way 1 of set 5
        add_vec(l2_cache_pkg::op_write, mk_addr(2, 5, 3),
                128'hbeef_0000_cafe_0000_f00d_0000_d00d_0000, 3'd0, k_clean, '0);
        add_vec(l2_cache_pkg::op_read, mk_addr(2, 5, 3), '0, 3'd0, k_hit, '0);
        // four dirty lines in set 20 then hinted evictions
        for (int t = 0; t < 4; t++) begin
            add_vec(l2_cache_pkg::op_write, mk_addr(10 + t, 20, t), {4{32'hc0de_0000 + 32'(t)}},
                    3'd0, k_clean, '0);
        end
        add_vec(l2_cache_pkg::op_read, mk_addr(14, 20, 0), '0, 3'b101, k_dirty, {17'd13, 9'd20});
        add_vec(l2_cache_pkg::op_read, mk_addr(13, 20, 3), '0, 3'b000, k_dirty, {17'd10, 9'd20});
        add_vec(l2_cache_pkg::op_read, mk_addr(10, 20, 0), '0, 3'b010, k_dirty, {17'd11, 9'd20});
        add_vec(l2_cache_pkg::op_read, mk_addr(11, 20, 1), '0, 3'b001, k_dirty, {17'd12, 9'd20});
        add_vec(l2_cache_pkg::op_read, mk_addr(14, 20, 2), '0, 3'b001, k_hit, '0);
        for (int i = 0; i < 200; i++) begin
            r  = lcg_next();
            ln = int'(r[31:24]) % 12;  // twelve lines over sets 100 to 102
            add_vec(r[23] ? l2_cache_pkg::op_write : l2_cache_pkg::op_read,
                    mk_addr(64 + ln / 3, 100 + ln % 3, int'(r[22:21])),
                    {lcg_next(), lcg_next(), lcg_next(), lcg_next()}, r[20:18], k_any, '0);
        end
    endfunction

    task automatic check(input logic [511:0] got, input logic [511:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic apply_vec(input vec_t v);
        int           lat;
        int           rd0;
        int           wb0;
        logic [127:0] exp;
        logic [511:0] wb_exp;
        wb_exp = shadow_line(v.wb_line);
        if (v.op == l2_cache_pkg::op_write) begin
            shadow[v.addr[31:4]] = v.wdata;
        end
        exp = v.use_shadow ? shadow_word(v.addr[31:4]) : v.exp;
        rd0 = rd_count;
        wb0 = wb_count;
        @(posedge clk);
        req       <= 1'b1;
        req_op    <= v.op;
        req_addr  <= v.addr;
        req_wdata <= v.wdata;
        plru      <= v.plru;
        lat = 0;
        do begin
            @(posedge clk);
            req <= 1'b0;
            lat++;
            @(negedge clk);
            // busy stays up until the response cycle
            check(512'(busy), 512'(!rsp_valid), "busy level while a request is in flight");
        end while (!rsp_valid);
        check(512'(rsp_data), 512'(exp), "response word");
        if (v.kind == k_hit) begin
            check(512'(lat), 512'(2), "hit latency in cycles");
            check(512'(rd_count - rd0 + wb_count - wb0), '0, "memory requests on a hit");
        end else if (v.kind != k_any) begin
            check(512'(rd_count - rd0), 512'(1), "refill reads");
            check(512'(last_rd_line), 512'(v.addr[31:6]), "refill line address");
            check(512'(wb_count - wb0), 512'(v.kind == k_dirty), "write-backs");
            if (v.kind == k_dirty) begin
                check(512'(last_wb_line), 512'(v.wb_line), "write-back line address");
                check(last_wb_data, wb_exp, "write-back line data");
            end
        end
    endtask

    // memory answers 1 to 4 cycles after it sees mem_req
    always @(posedge clk) begin
        logic [31:0] r;
        mem_done <= 1'b0;
        if (!mem_req || mem_done) begin
            mem_wait = -1;
        end else if (mem_wait < 0) begin
            r        = lcg_next();
            mem_wait = int'(r[17:16]);
        end else if (mem_wait == 0) begin
            mem_done <= 1'b1;
            mem_wait = -1;
            if (mem_we) begin
                mem_lines[mem_addr] = mem_wdata;
                wb_count++;
                last_wb_line = mem_addr;
                last_wb_data = mem_wdata;
            end else begin
                mem_rdata <= mem_lines.exists(mem_addr) ? mem_lines[mem_addr]
                                                        : pattern_line(mem_addr);
                rd_count++;
                last_rd_line = mem_addr;
            end
        end else begin
            mem_wait--;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: no response after %0d cycles", limit);
            $display("Simulation failed");
            $fatal(1, "run timed out");
        end
    end

    initial begin
        rst_n     = 1'b0;
        req       = 1'b0;
        req_op    = l2_cache_pkg::op_read;
        req_addr  = '0;
        req_wdata = '0;
        plru      = '0;
        build_table();
        limit = tbl.size() * 200 + 8;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check(512'({busy, rsp_valid, mem_req}), '0, "busy, rsp_valid, mem_req after reset");
        foreach (tbl[i]) begin
            apply_vec(tbl[i]);
        end
        @(negedge clk);
        if (uut.u_props.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Protocol assertions failed %0d times", uut.u_props.fail_count);
            $display("Simulation failed");
            $fatal(1, "protocol errors");
        end
    end

endmodule

// ==== l2_cache_props.sv ====
// protocol assertions on the cache top level
// attached to l2_cache_top with bind from the testbench
`timescale 1ns/1ps

module l2_cache_props (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 busy,
    input logic                                 rsp_valid,
    input logic                                 mem_req,
    input logic                                 mem_we,
    input logic [l2_cache_pkg::line_addr_w-1:0] mem_addr,
    input logic                                 mem_done,
    input l2_cache_pkg::l2_state_e              state
);

    int fail_count = 0;

    rsp_single: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |=> !rsp_valid)
        else begin
            fail_count++;
            $error("rsp_valid stayed high for two cycles");
        end

    // memory request held with direction and address until done
    mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_done |=> mem_req && $stable(mem_we) && $stable(mem_addr))
        else begin
            fail_count++;
            $error("mem_req dropped or changed before mem_done");
        end

    mem_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !mem_req)
        else begin
            fail_count++;
            $error("mem_req high while the cache is idle");
        end

    // memory writes only happen in write-back
    mem_dir: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> mem_we == (state == l2_cache_pkg::st_write_back))
        else begin
            fail_count++;
            $error("mem_we does not match the controller state");
        end

endmodule

// ==== l2_cache_top.sv ====
// top level of the 4-way write-back L2 cache, one requester, one memory port
// index_w sets the number of sets per way and is passed to every block
`timescale 1ns/1ps

module l2_cache_top #(
    parameter int index_w = 9
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   req,
    input  l2_cache_pkg::l2_op_e                   req_op,
    input  logic [l2_cache_pkg::addr_w-1:0]        req_addr,
    input  logic [l2_cache_pkg::word_w-1:0]        req_wdata,
    input  logic [2:0]                             plru,
    output logic                                   busy,
    output logic                                   rsp_valid,
    output logic [l2_cache_pkg::word_w-1:0]        rsp_data,
    output logic                                   mem_req,
    output logic                                   mem_we,
    output logic [l2_cache_pkg::line_addr_w-1:0]   mem_addr,
    output logic [l2_cache_pkg::line_w-1:0]        mem_wdata,
    input  logic [l2_cache_pkg::line_w-1:0]        mem_rdata,
    input  logic                                   mem_done
);

    localparam int tag_w = l2_cache_pkg::addr_w - l2_cache_pkg::offset_lsb - index_w;

    l2_cache_pkg::l2_req_t     cur_req;
    l2_cache_pkg::lookup_t     lookup;
    l2_cache_pkg::l2_state_e   state;       // visible for bound checks
    l2_cache_pkg::store_cmd_e  store_cmd;
    l2_cache_pkg::store_wr_t   store_wr;
    l2_cache_pkg::way_t        target_way;
    logic [index_w-1:0]        index;

    logic [l2_cache_pkg::num_ways-1:0][tag_w-1:0]                way_tag;
    logic [l2_cache_pkg::num_ways-1:0]                           way_valid;
    logic [l2_cache_pkg::num_ways-1:0]                           way_dirty;
    logic [l2_cache_pkg::num_ways-1:0][l2_cache_pkg::line_w-1:0] way_line;

    l2_ctrl_fsm #(.index_w(index_w)) u_fsm (
        .clk, .rst_n, .req, .req_op, .req_addr, .req_wdata,
        .lookup, .mem_done, .cur_req, .index, .state, .store_cmd,
        .target_way, .busy, .rsp_valid, .mem_req, .mem_we
    );

    l2_tag_lookup #(.index_w(index_w)) u_lookup (
        .cur_req, .plru, .way_tag, .way_valid, .way_dirty, .lookup
    );

    l2_line_path #(.index_w(index_w)) u_line (
        .clk, .rst_n, .cur_req, .lookup, .store_cmd, .target_way, .mem_we,
        .rsp_valid, .way_tag, .way_line, .mem_rdata, .store_wr, .rsp_data,
        .mem_addr, .mem_wdata
    );

    l2_way_store #(.index_w(index_w)) u_store (
        .clk, .rst_n, .index, .store_cmd, .store_wr,
        .way_tag, .way_valid, .way_dirty, .way_line
    );

endmodule

// ==== l2_line_path.sv ====
// result stage of the L2 cache
// forms array write commands, the registered response word and the
// memory line address and write data
`timescale 1ns/1ps

module l2_line_path #(
    parameter int index_w = 9
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  l2_cache_pkg::l2_req_t                       cur_req,
    input  l2_cache_pkg::lookup_t                       lookup,
    input  l2_cache_pkg::store_cmd_e                    store_cmd,
    input  l2_cache_pkg::way_t                          target_way,
    input  logic                                        mem_we,
    input  logic                                        rsp_valid,
    input  logic [l2_cache_pkg::num_ways-1:0]
                 [l2_cache_pkg::addr_w-l2_cache_pkg::offset_lsb-index_w-1:0] way_tag,
    input  logic [l2_cache_pkg::num_ways-1:0][l2_cache_pkg::line_w-1:0] way_line,
    input  logic [l2_cache_pkg::line_w-1:0]             mem_rdata,
    output l2_cache_pkg::store_wr_t                     store_wr,
    output logic [l2_cache_pkg::word_w-1:0]             rsp_data,
    output logic [l2_cache_pkg::line_addr_w-1:0]        mem_addr,
    output logic [l2_cache_pkg::line_w-1:0]             mem_wdata
);

    localparam int tag_w = l2_cache_pkg::addr_w - l2_cache_pkg::offset_lsb - index_w;

    l2_cache_pkg::word_sel_t          word_sel;
    logic [index_w-1:0]               set_idx;
    logic [l2_cache_pkg::line_w-1:0]  hit_line;

    assign word_sel = cur_req.addr[l2_cache_pkg::offset_lsb-1 -: 2];
    assign set_idx  = cur_req.addr[l2_cache_pkg::offset_lsb +: index_w];
    assign hit_line = way_line[lookup.hit_way];

    always_comb begin
        store_wr     = '0;
        store_wr.way = target_way;
        if (store_cmd == l2_cache_pkg::cmd_fill_line) begin
            store_wr.word_en            = '1;
            store_wr.tag[tag_w-1:0]     = cur_req.addr[l2_cache_pkg::addr_w-1 -: tag_w];
            store_wr.dirty              = 1'b0;  // fresh from memory
            store_wr.line               = mem_rdata;
        end else begin
            // word write keeps the stored tag, word lands by its enable
            store_wr.word_en[word_sel]  = (store_cmd == l2_cache_pkg::cmd_write_word);
            store_wr.tag[tag_w-1:0]     = way_tag[target_way];
            store_wr.dirty              = 1'b1;
            store_wr.line               = {l2_cache_pkg::words_per_line{cur_req.wdata}};
        end
    end

    // response word, captured from the hitting lookup and held across the pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_data <= '0;
        end else if (lookup.hit && !rsp_valid) begin
            if (cur_req.op == l2_cache_pkg::op_write) begin
                rsp_data <= cur_req.wdata;  // word just written
            end else begin
                rsp_data <= hit_line[word_sel*l2_cache_pkg::word_w +: l2_cache_pkg::word_w];
            end
        end
    end

    // write-back goes to the victim line, everything else to the request line
    assign mem_addr  = mem_we ? {lookup.victim_tag[tag_w-1:0], set_idx}
                              : cur_req.addr[l2_cache_pkg::addr_w-1:l2_cache_pkg::offset_lsb];
    assign mem_wdata = way_line[target_way];

endmodule

// ==== l2_ctrl_fsm.sv ====
// execute stage of the L2 cache
// latches the request and sequences lookup, dirty write-back and refill,
// memory control levels are registered and drop on mem_done
`timescale 1ns/1ps

module l2_ctrl_fsm #(
    parameter int index_w = 9
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   req,
    input  l2_cache_pkg::l2_op_e                   req_op,
    input  logic [l2_cache_pkg::addr_w-1:0]        req_addr,
    input  logic [l2_cache_pkg::word_w-1:0]        req_wdata,
    input  l2_cache_pkg::lookup_t                  lookup,
    input  logic                                   mem_done,
    output l2_cache_pkg::l2_req_t                  cur_req,
    output logic [index_w-1:0]                     index,
    output l2_cache_pkg::l2_state_e                state,
    output l2_cache_pkg::store_cmd_e               store_cmd,
    output l2_cache_pkg::way_t                     target_way,
    output logic                                   busy,
    output logic                                   rsp_valid,
    output logic                                   mem_req,
    output logic                                   mem_we
);

    l2_cache_pkg::way_t victim_way;   // held from the missing lookup

    assign index = cur_req.addr[l2_cache_pkg::offset_lsb +: index_w];
    assign busy  = (state != l2_cache_pkg::st_idle);

    // request and victim registers, payload only
    always_ff @(posedge clk) begin
        if (state == l2_cache_pkg::st_idle && req) begin
            cur_req.addr  <= req_addr;
            cur_req.op    <= req_op;
            cur_req.wdata <= req_wdata;
        end
        if (state == l2_cache_pkg::st_lookup && !lookup.hit) begin
            victim_way <= lookup.victim_way;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= l2_cache_pkg::st_idle;
            rsp_valid <= 1'b0;
            mem_req   <= 1'b0;
            mem_we    <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;  // single cycle pulse
            case (state)
                l2_cache_pkg::st_idle: begin
                    if (req) begin
                        state <= l2_cache_pkg::st_lookup;
                    end
                end
                l2_cache_pkg::st_lookup: begin
                    if (lookup.hit) begin
                        rsp_valid <= 1'b1;
                        state     <= l2_cache_pkg::st_idle;
                    end else if (lookup.victim_dirty) begin
                        mem_req <= 1'b1;  // write the victim out first
                        mem_we  <= 1'b1;
                        state   <= l2_cache_pkg::st_write_back;
                    end else begin
                        mem_req <= 1'b1;
                        mem_we  <= 1'b0;
                        state   <= l2_cache_pkg::st_refill;
                    end
                end
                l2_cache_pkg::st_write_back: begin
                    if (mem_req && mem_done) begin
                        mem_req <= 1'b0;  // one idle cycle before the refill read
                        mem_we  <= 1'b0;
                        state   <= l2_cache_pkg::st_refill;
                    end
                end
                l2_cache_pkg::st_refill: begin
                    if (mem_req && mem_done) begin
                        mem_req <= 1'b0;
                        state   <= l2_cache_pkg::st_lookup;  // replay, now a hit
                    end else begin
                        mem_req <= 1'b1;
                    end
                end
                default: begin
                    state <= l2_cache_pkg::st_idle;
                end
            endcase
        end
    end

    // array write kind and the way it goes to
    always_comb begin
        store_cmd  = l2_cache_pkg::cmd_none;
        target_way = victim_way;
        if (state == l2_cache_pkg::st_lookup && lookup.hit) begin
            target_way = lookup.hit_way;
            if (cur_req.op == l2_cache_pkg::op_write) begin
                store_cmd = l2_cache_pkg::cmd_write_word;
            end
        end else if (state == l2_cache_pkg::st_refill && mem_req && mem_done) begin
            store_cmd = l2_cache_pkg::cmd_fill_line;  // line lands on the leaving edge
        end
    end

endmodule

// ==== l2_tag_lookup.sv ====
// decode stage of the L2 cache
// compares the request tag against all ways, picks the hit way and the victim
`timescale 1ns/1ps

module l2_tag_lookup #(
    parameter int index_w = 9
) (
    input  l2_cache_pkg::l2_req_t                           cur_req,
    input  logic [2:0]                                      plru,
    input  logic [l2_cache_pkg::num_ways-1:0]
                 [l2_cache_pkg::addr_w-l2_cache_pkg::offset_lsb-index_w-1:0] way_tag,
    input  logic [l2_cache_pkg::num_ways-1:0]               way_valid,
    input  logic [l2_cache_pkg::num_ways-1:0]               way_dirty,
    output l2_cache_pkg::lookup_t                           lookup
);

    localparam int tag_w = l2_cache_pkg::addr_w - l2_cache_pkg::offset_lsb - index_w;

    logic [tag_w-1:0]        req_tag;
    logic                    hit;
    l2_cache_pkg::way_t      hit_way;
    logic                    any_invalid;
    l2_cache_pkg::way_t      inv_way;
    l2_cache_pkg::way_t      victim;

    assign req_tag = cur_req.addr[l2_cache_pkg::addr_w-1 -: tag_w];

    always_comb begin
        hit         = 1'b0;
        hit_way     = '0;
        any_invalid = 1'b0;
        inv_way     = '0;
        // walk down so the lowest matching way wins
        for (int w = l2_cache_pkg::num_ways - 1; w >= 0; w--) begin
            if (way_valid[w] && way_tag[w] == req_tag) begin
                hit     = 1'b1;
                hit_way = l2_cache_pkg::way_t'(w);
            end
            if (!way_valid[w]) begin
                any_invalid = 1'b1;
                inv_way     = l2_cache_pkg::way_t'(w);  // first invalid way
            end
        end
    end

    // tree pseudo-LRU: bit 0 picks the half, bit 1 or 2 the way in it
    always_comb begin
        if (any_invalid) begin
            victim = inv_way;
        end else if (!plru[0]) begin
            victim = plru[1] ? 2'd1 : 2'd0;
        end else begin
            victim = plru[2] ? 2'd3 : 2'd2;
        end
    end

    always_comb begin
        lookup              = '0;
        lookup.hit          = hit;
        lookup.hit_way      = hit_way;
        lookup.victim_way   = victim;
        lookup.victim_dirty = way_valid[victim] & way_dirty[victim];
        lookup.victim_tag[tag_w-1:0] = way_tag[victim];
    end

endmodule

// ==== l2_way_store.sv ====
// tag, valid, dirty and line storage for the four ways
// reads are combinational at index, writes take one clock
`timescale 1ns/1ps

module l2_way_store #(
    parameter int index_w = 9
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [index_w-1:0]                          index,
    input  l2_cache_pkg::store_cmd_e                    store_cmd,
    input  l2_cache_pkg::store_wr_t                     store_wr,
    output logic [l2_cache_pkg::num_ways-1:0]
                 [l2_cache_pkg::addr_w-l2_cache_pkg::offset_lsb-index_w-1:0] way_tag,
    output logic [l2_cache_pkg::num_ways-1:0]           way_valid,
    output logic [l2_cache_pkg::num_ways-1:0]           way_dirty,
    output logic [l2_cache_pkg::num_ways-1:0][l2_cache_pkg::line_w-1:0] way_line
);

    localparam int tag_w = l2_cache_pkg::addr_w - l2_cache_pkg::offset_lsb - index_w;
    localparam int sets  = 1 << index_w;

    logic [tag_w-1:0]                tag_mem  [l2_cache_pkg::num_ways][sets];
    logic [l2_cache_pkg::line_w-1:0] line_mem [l2_cache_pkg::num_ways][sets];
    logic [l2_cache_pkg::num_ways-1:0][sets-1:0] valid_bits;
    logic [l2_cache_pkg::num_ways-1:0][sets-1:0] dirty_bits;
    logic                            wr_en;

    assign wr_en = (store_cmd != l2_cache_pkg::cmd_none);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr_en) begin
            valid_bits[store_wr.way][index] <= 1'b1;
            dirty_bits[store_wr.way][index] <= store_wr.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[store_wr.way][index] <= store_wr.tag[tag_w-1:0];
            for (int w = 0; w < l2_cache_pkg::words_per_line; w++) begin
                if (store_wr.word_en[w]) begin
                    line_mem[store_wr.way][index][w*l2_cache_pkg::word_w +: l2_cache_pkg::word_w]
                        <= store_wr.line[w*l2_cache_pkg::word_w +: l2_cache_pkg::word_w];
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
            way_tag[w]   = tag_mem[w][index];
            way_valid[w] = valid_bits[w][index];
            way_dirty[w] = dirty_bits[w][index];
            way_line[w]  = line_mem[w][index];
        end
    end

endmodule

// ==== l2_cache_pkg.sv ====
// shared widths, enums and structs for the 4-way write-back L2 cache
// used by the RTL and the testbench through scoped names
package l2_cache_pkg;

    localparam int addr_w         = 32;
    localparam int line_w         = 512;
    localparam int word_w         = 128;
    localparam int words_per_line = 4;
    localparam int num_ways       = 4;
    localparam int offset_lsb     = 6;    // byte offset bits inside a line
    localparam int line_addr_w    = addr_w - offset_lsb;

    typedef logic [1:0] way_t;
    typedef logic [1:0] word_sel_t;        // address bits 5:4

    typedef enum logic {
        op_read,
        op_write
    } l2_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_write_back,
        st_refill
    } l2_state_e;

    typedef enum logic [1:0] {
        cmd_none,
        cmd_write_word,
        cmd_fill_line
    } store_cmd_e;

    // latched request
    typedef struct packed {
        logic [addr_w-1:0] addr;
        l2_op_e            op;
        logic [word_w-1:0] wdata;
    } l2_req_t;

    // tags are right-aligned in line_addr_w wide fields,
    // the live width depends on the index width of the instance
    typedef struct packed {
        logic                   hit;
        way_t                   hit_way;
        way_t                   victim_way;
        logic                   victim_dirty;  // valid and dirty
        logic [line_addr_w-1:0] victim_tag;
    } lookup_t;

    // one array write, the set index travels beside it
    typedef struct packed {
        way_t                      way;
        logic [words_per_line-1:0] word_en;
        logic [line_addr_w-1:0]    tag;
        logic                      dirty;
        logic [line_w-1:0]         line;
    } store_wr_t;

endpackage
